// ==== Bender.yml ====
package:
  name: fetch_top

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fetch_pkg.sv
      - verilog/pred_table.sv
      - verilog/branch_predictor.sv
      - verilog/instr_mem.sv
      - verilog/fetch_stage.sv
      - verilog/fetch_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verif/fetch_checker.sv
      - verif/fetch_tb.sv

// ==== fetch_top.f ====
+incdir+verilog
verilog/fetch_pkg.sv
verilog/pred_table.sv
verilog/branch_predictor.sv
verilog/instr_mem.sv
verilog/fetch_stage.sv
verilog/fetch_top.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

// ==== verif/fetch_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_checker (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        psel,
  input  wire                        penable,
  input  wire                        pwrite,
  input  wire [`FETCH_XLEN-1:0]      paddr,
  input  wire [`FETCH_XLEN-1:0]      pwdata,
  input  wire [`FETCH_XLEN-1:0]      prdata,
  input  wire                        pready,
  input  wire                        pslverr,
  input  wire                        stall,
  input  wire fetch_pkg::resolve_t   resolve,
  input  wire fetch_pkg::fetch_out_t fout,
  output int                         fout_errors,  // Mismatches on the decode side
  output int                         apb_errors    // Mismatches on the host side
);

  import fetch_pkg::*;

  localparam int WB = $clog2(`IMEM_WORDS);    // Top bit of the word index
  localparam int PB = $clog2(`PRED_ENTRIES);  // Top bit of the predictor index

  logic [`FETCH_XLEN-1:0] mem_m [`IMEM_WORDS];    // Memory image, X until loaded
  bht_cnt_t               cnt_m [`PRED_ENTRIES];  // Direction counters
  logic                   vld_m [`PRED_ENTRIES];  // Target known
  logic [`FETCH_XLEN-1:0] tgt_m [`PRED_ENTRIES];  // Cached targets
  logic [`FETCH_XLEN-1:0] pc_m;                   // Expected fetch PC
  logic                   access;
  logic                   bad_addr;
  pred_idx_t              look;
  pred_idx_t              upd;
  logic                   pred_m;

  assign access   = psel & penable;                             // APB access phase
  assign bad_addr = paddr[0] | (paddr >= 2 * `IMEM_WORDS);      // Odd or past the end
  assign look     = pc_m[PB:1];
  assign upd      = resolve.pc[PB:1];
  assign pred_m   = cnt_m[look][1] & vld_m[look];               // Strong enough and known

  initial begin
    fout_errors = 0;
    apb_errors  = 0;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_m <= `RESET_PC;
      for (int i = 0; i < `PRED_ENTRIES; i++) begin
        cnt_m[i] <= 2'd1;  // Weakly not taken
        vld_m[i] <= 1'b0;
        tgt_m[i] <= '0;
      end
    end else begin
      if (access && pwrite && !bad_addr) mem_m[paddr[WB:1]] <= pwdata;  // Good writes only
      if (resolve.valid) begin
        if (resolve.taken) begin
          if (cnt_m[upd] != 2'd3) cnt_m[upd] <= cnt_m[upd] + 2'd1;
          vld_m[upd] <= 1'b1;
          tgt_m[upd] <= resolve.target;
        end else if (cnt_m[upd] != 2'd0) begin
          cnt_m[upd] <= cnt_m[upd] - 2'd1;
        end
      end
      // Recovery beats stall, stall beats prediction
      if (resolve.valid && resolve.mispredicted)
        pc_m <= resolve.taken ? resolve.target : resolve.pc + 16'd2;
      else if (!stall)
        pc_m <= pred_m ? tgt_m[look] : pc_m + 16'd2;
    end
  end

  //////////////////////////////////////////////////
  // Compare mid cycle
  //////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [15:0] exp,
                             input logic [15:0] act, input logic host_side);
    if (act !== exp) begin
      $display("error %0t %s expected %h actual %h", $time, name, exp, act);
      if (host_side) apb_errors++;
      else fout_errors++;
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      check_value("fout.pc", pc_m, fout.pc, 1'b0);
      check_value("fout.inst", mem_m[pc_m[WB:1]], fout.inst, 1'b0);  // Wraps like the memory
      check_value("fout.pred_taken", pred_m, fout.pred_taken, 1'b0);
      check_value("fout.pred_target", tgt_m[look], fout.pred_target, 1'b0);
      check_value("pready", access, pready, 1'b1);                    // No wait states
      check_value("pslverr", access & bad_addr, pslverr, 1'b1);
      if (access && !pwrite && !bad_addr)
        check_value("prdata", mem_m[paddr[WB:1]], prdata, 1'b1);
    end
  end

endmodule

`default_nettype wire

// ==== verif/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_tb;

  import fetch_pkg::*;

  localparam int RUN_CYCLES  = 2000;
  localparam int APB_TIMEOUT = 16;                      // Cycles to wait for pready
  localparam logic [15:0] TRAIN_TGT = 16'h0040;         // Target used for training

  logic                   clk;
  logic                   rst_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`FETCH_XLEN-1:0] paddr;
  logic [`FETCH_XLEN-1:0] pwdata;
  wire  [`FETCH_XLEN-1:0] prdata;
  wire                    pready;
  wire                    pslverr;
  logic                   stall;
  resolve_t               resolve;
  fetch_out_t             fout;
  integer                 seed;
  int                     tb_errors;    // Directed checks and timeouts
  int                     fout_errors;
  int                     apb_errors;

  initial clk = 1'b0;
  always #50 clk = ~clk;  // 100 ns period

  fetch_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .stall   (stall),
    .resolve (resolve),
    .fout    (fout)
  );

  fetch_checker u_chk (
    .clk (clk), .rst_n (rst_n), .psel (psel), .penable (penable), .pwrite (pwrite),
    .paddr (paddr), .pwdata (pwdata), .prdata (prdata), .pready (pready),
    .pslverr (pslverr), .stall (stall), .resolve (resolve), .fout (fout),
    .fout_errors (fout_errors), .apb_errors (apb_errors)
  );

  //////////////////////////////////////////////////
  // Host side
  //////////////////////////////////////////////////
  task automatic apb_transfer(input logic write, input logic [15:0] addr,
                              input logic [15:0] data);
    int waited;
    waited = 0;
    @(posedge clk);
    psel    <= 1'b1;  // Setup phase
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;  // Access phase
    @(negedge clk);
    while (!pready && waited < APB_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!pready) begin
      $display("APB transfer at address %h got no pready within %0d cycles", addr, APB_TIMEOUT);
      tb_errors++;
    end
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Decode side
  //////////////////////////////////////////////////
  // One resolve at the held PC, then look at the prediction a cycle after the update
  task automatic train_step(input logic taken, input logic expect_pred);
    @(posedge clk);
    resolve.valid        <= 1'b1;
    resolve.pc           <= `RESET_PC;
    resolve.taken        <= taken;
    resolve.target       <= TRAIN_TGT;
    resolve.mispredicted <= 1'b0;  // PC must stay put
    @(posedge clk);
    resolve.valid <= 1'b0;
    @(negedge clk);
    if (fout.pred_taken !== expect_pred) begin
      $display("error %0t fout.pred_taken expected %b actual %b",
               $time, expect_pred, fout.pred_taken);
      tb_errors++;
    end
  endtask

  task automatic random_cycle();
    pred_idx_t   idx;
    logic        taken;
    logic        guess;
    logic [15:0] bpc;
    logic [15:0] btgt;
    @(posedge clk);
    stall         <= ({$random(seed)} % 5) == 0;
    resolve.valid <= 1'b0;
    if (({$random(seed)} % 3) == 0) begin
      bpc   = $random(seed) & 16'hfffe;   // Even branch PC
      btgt  = $random(seed) & 16'hfffe;
      taken = $random(seed) & 1;
      idx   = bpc[$clog2(`PRED_ENTRIES):1];
      guess = u_chk.cnt_m[idx][1] & u_chk.vld_m[idx];  // What the model predicts there
      resolve.valid  <= 1'b1;
      resolve.pc     <= bpc;
      resolve.taken  <= taken;
      resolve.target <= btgt;
      // Wrong direction, wrong target, or an occasional forced redirect
      resolve.mispredicted <= (guess != taken) || (taken && u_chk.tgt_m[idx] != btgt) ||
                              (({$random(seed)} % 8) == 0);
    end
  endtask

  //////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////
  initial begin
    seed      = 32'hdd54c4e4;
    tb_errors = 0;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    stall     = 1'b1;  // PC parked during load
    resolve   = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (fout.pc !== `RESET_PC) begin
      $display("error %0t fout.pc expected %h actual %h", $time, `RESET_PC, fout.pc);
      tb_errors++;
    end
    if (fout.pred_taken !== 1'b0) begin
      $display("error %0t fout.pred_taken expected 0 actual %b", $time, fout.pred_taken);
      tb_errors++;
    end
    for (int a = 0; a < `IMEM_WORDS; a++) apb_transfer(1'b1, a * 2, $random(seed));
    // Illegal transfers, odd and out of range
    apb_transfer(1'b1, 16'h0003, 16'hdead);
    apb_transfer(1'b1, 2 * `IMEM_WORDS, 16'hbeef);  // Aliases word 0 if decoded wrong
    apb_transfer(1'b1, 16'hfffe, 16'h1234);
    apb_transfer(1'b0, 16'h0001, 16'h0000);
    apb_transfer(1'b0, 2 * `IMEM_WORDS + 16, 16'h0000);
    for (int a = 0; a < `IMEM_WORDS; a++) apb_transfer(1'b0, a * 2, 16'h0000);
    // Counter walk 1 to 0 to 3 to 1
    train_step(1'b0, 1'b0);
    train_step(1'b1, 1'b0);
    train_step(1'b1, 1'b1);
    train_step(1'b1, 1'b1);
    train_step(1'b0, 1'b1);
    train_step(1'b0, 1'b0);
    for (int c = 0; c < RUN_CYCLES; c++) random_cycle();
    @(posedge clk);
    stall         <= 1'b0;
    resolve.valid <= 1'b0;
    repeat (2) @(negedge clk);  // Last compares
    $display("fout errors %0d, apb errors %0d, testbench errors %0d",
             fout_errors, apb_errors, tb_errors);
    if (fout_errors == 0 && apb_errors == 0 && tb_errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module branch_predictor (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire [`FETCH_XLEN-1:0]   pc,           // Current fetch PC
  input  wire fetch_pkg::resolve_t resolve,     // Outcome from decode
  output logic                    pred_taken,   // Jump to pred_target next cycle
  output logic [`FETCH_XLEN-1:0]  pred_target
);

  import fetch_pkg::*;

  localparam int IDX_W = $bits(pred_idx_t);  // 4 index bits above bit 0

  pred_idx_t  look_idx;   // Index of the fetch PC
  pred_idx_t  upd_idx;    // Index of the resolved branch
  bht_cnt_t   bht_rd;     // Counter seen by lookup
  bht_cnt_t   bht_old;    // Counter at the branch before update
  bht_cnt_t   bht_new;    // Counter after saturating step
  btb_entry_t btb_rd;     // Target entry seen by lookup
  btb_entry_t btb_wr;     // Entry written by a taken branch
  logic       btb_wr_en;

  // Bit 0 is always zero for 16-bit instructions, skip it
  assign look_idx = pc[IDX_W:1];
  assign upd_idx  = resolve.pc[IDX_W:1];

  //////////////////////////////////////////////////
  // Direction counters
  //////////////////////////////////////////////////
  pred_table #(
    .ENTRY_T  (bht_cnt_t),
    .DEPTH    (`PRED_ENTRIES),
    .INIT_VAL (BHT_WEAK_NT)
  ) u_bht (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_idx  (look_idx),
    .rd_data (bht_rd),
    .wr_en   (resolve.valid),  // Every resolved branch trains its counter
    .wr_idx  (upd_idx),
    .wr_data (bht_new),
    .wr_old  (bht_old)
  );

  // Count toward the actual direction, stick at 0 and 3
  always_comb begin
    bht_new = bht_old;
    if (resolve.taken) begin
      if (bht_old != BHT_MAX) bht_new = bht_old + 2'd1;
    end else if (bht_old != '0) begin
      bht_new = bht_old - 2'd1;
    end
  end

  //////////////////////////////////////////////////
  // Target buffer
  //////////////////////////////////////////////////
  assign btb_wr_en    = resolve.valid & resolve.taken;  // Only taken branches teach a target
  assign btb_wr.valid = 1'b1;
  assign btb_wr.target = resolve.target;

  pred_table #(
    .ENTRY_T  (btb_entry_t),
    .DEPTH    (`PRED_ENTRIES),
    .INIT_VAL (BTB_EMPTY)
  ) u_btb (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_idx  (look_idx),
    .rd_data (btb_rd),
    .wr_en   (btb_wr_en),
    .wr_idx  (upd_idx),
    .wr_data (btb_wr),
    .wr_old  ()               // Overwritten blindly
  );

  // Taken needs both a strong enough counter and a known target
  assign pred_taken  = bht_rd[1] & btb_rd.valid;
  assign pred_target = btb_rd.target;

  // Decode reports 16-bit aligned branches only
  a_resolve_even : assert property (@(posedge clk) disable iff (!rst_n)
    resolve.valid |-> !resolve.pc[0])
    else $error("resolve with odd branch PC %h", resolve.pc);

endmodule

`default_nettype wire

// ==== verilog/fetch_defines.svh ====
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Width of the PC and of one instruction word
`define FETCH_XLEN 16

//////////////////////////////////////////////////
// Storage sizes
//////////////////////////////////////////////////

`define IMEM_WORDS 256   // Instruction memory depth in 16-bit words
`define PRED_ENTRIES 16  // Counter and target table depth

// PC value loaded while rst_n is low
`define RESET_PC 16'h0000

`endif

// ==== verilog/fetch_pkg.sv ====
`default_nettype none

`include "fetch_defines.svh"

package fetch_pkg;

  //////////////////////////////////////////////////
  // Predictor entries
  //////////////////////////////////////////////////
  typedef logic [1:0] bht_cnt_t;                   // 2-bit saturating counter, MSB means taken
  localparam bht_cnt_t BHT_WEAK_NT = 2'd1;         // Reset state of every counter
  localparam bht_cnt_t BHT_MAX     = 2'd3;         // Strongly taken

  typedef struct packed {
    logic                   valid;                 // Target was written by a taken branch
    logic [`FETCH_XLEN-1:0] target;                // Cached branch target
  } btb_entry_t;
  localparam btb_entry_t BTB_EMPTY = '0;           // Invalid entry

  typedef logic [$clog2(`PRED_ENTRIES)-1:0] pred_idx_t;  // Table index from PC[4:1]

  //////////////////////////////////////////////////
  // Decode side interfaces
  //////////////////////////////////////////////////
  typedef struct packed {
    logic                   valid;                 // Struct counts only when set
    logic [`FETCH_XLEN-1:0] pc;                    // PC of the resolved branch
    logic                   taken;                 // Actual direction
    logic [`FETCH_XLEN-1:0] target;                // Actual target
    logic                   mispredicted;          // Fetch went the wrong way
  } resolve_t;

  typedef struct packed {
    logic [`FETCH_XLEN-1:0] pc;                    // Address of inst
    logic [`FETCH_XLEN-1:0] inst;                  // Instruction word at pc
    logic                   pred_taken;            // Predictor says jump
    logic [`FETCH_XLEN-1:0] pred_target;           // Where it would jump
  } fetch_out_t;

endpackage

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_stage (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     stall,      // Hold the PC
  input  wire fetch_pkg::resolve_t resolve,   // Branch outcome from decode
  output logic [`FETCH_XLEN-1:0]  imem_addr,  // To instruction memory
  input  wire [`FETCH_XLEN-1:0]   imem_data,  // Word back, same cycle
  output fetch_pkg::fetch_out_t   fout        // To decode
);

  import fetch_pkg::*;

  localparam logic [`FETCH_XLEN-1:0] PC_STEP = 2;  // One 16-bit instruction

  logic [`FETCH_XLEN-1:0] pc_q;         // PC register
  logic [`FETCH_XLEN-1:0] pc_plus2;     // Sequential next
  logic [`FETCH_XLEN-1:0] pc_recover;   // Correct path after a mispredict
  logic [`FETCH_XLEN-1:0] pc_next;
  logic                   redirect;
  logic                   pred_taken;
  logic [`FETCH_XLEN-1:0] pred_target;

  branch_predictor u_bp (
    .clk         (clk),
    .rst_n       (rst_n),
    .pc          (pc_q),
    .resolve     (resolve),
    .pred_taken  (pred_taken),
    .pred_target (pred_target)
  );

  //////////////////////////////////////////////////
  // Next PC selection
  //////////////////////////////////////////////////
  assign pc_plus2   = pc_q + PC_STEP;
  assign redirect   = resolve.valid & resolve.mispredicted;
  assign pc_recover = resolve.taken ? resolve.target : (resolve.pc + PC_STEP);

  // Redirect wins over stall, stall wins over prediction
  always_comb begin
    if (redirect)        pc_next = pc_recover;
    else if (stall)      pc_next = pc_q;
    else if (pred_taken) pc_next = pred_target;
    else                 pc_next = pc_plus2;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) pc_q <= `RESET_PC;
    else        pc_q <= pc_next;
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////
  assign imem_addr        = pc_q;
  assign fout.pc          = pc_q;
  assign fout.inst        = imem_data;   // No register between memory and decode
  assign fout.pred_taken  = pred_taken;
  assign fout.pred_target = pred_target;

  // Catches an odd target sneaking in through resolve or the target buffer
  a_pc_even : assert property (@(posedge clk) disable iff (!rst_n)
    !pc_q[0])
    else $error("fetch PC is odd %h", pc_q);

endmodule

`default_nettype wire

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_top (
  input  wire                     clk,
  input  wire                     rst_n,
  // Host APB port
  input  wire                     psel,
  input  wire                     penable,
  input  wire                     pwrite,
  input  wire [`FETCH_XLEN-1:0]   paddr,
  input  wire [`FETCH_XLEN-1:0]   pwdata,
  output wire [`FETCH_XLEN-1:0]   prdata,
  output wire                     pready,
  output wire                     pslverr,
  // Decode side
  input  wire                     stall,
  input  wire fetch_pkg::resolve_t resolve,
  output fetch_pkg::fetch_out_t   fout
);

  //////////////////////////////////////////////////
  // Fetch to memory
  //////////////////////////////////////////////////
  wire [`FETCH_XLEN-1:0] imem_addr;  // PC byte address
  wire [`FETCH_XLEN-1:0] imem_data;  // Instruction back, combinational

  fetch_stage u_fetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .resolve   (resolve),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .fout      (fout)
  );

  instr_mem u_imem (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch_addr (imem_addr),
    .fetch_data (imem_data),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr)
  );

endmodule

`default_nettype wire

// ==== verilog/instr_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module instr_mem (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire [`FETCH_XLEN-1:0]  fetch_addr,  // Byte address from the PC
  output logic [`FETCH_XLEN-1:0] fetch_data,  // Word at fetch_addr, same cycle
  // APB slave port for the host
  input  wire                    psel,
  input  wire                    penable,
  input  wire                    pwrite,
  input  wire [`FETCH_XLEN-1:0]  paddr,
  input  wire [`FETCH_XLEN-1:0]  pwdata,
  output logic [`FETCH_XLEN-1:0] prdata,
  output logic                   pready,
  output logic                   pslverr
);

  localparam int WADDR_W = $clog2(`IMEM_WORDS);        // Word index bits
  localparam logic [`FETCH_XLEN:0] BYTE_LIMIT = 2 * `IMEM_WORDS;  // First illegal byte

  logic [`FETCH_XLEN-1:0] mem_q [`IMEM_WORDS];  // Program storage, contents survive reset

  logic [WADDR_W-1:0] fetch_widx;  // Word picked by fetch
  logic [WADDR_W-1:0] apb_widx;    // Word picked by APB
  logic               apb_access;  // Second phase of a transfer
  logic               addr_err;    // Odd or past the end
  logic               apb_wr;      // Write that lands

  //////////////////////////////////////////////////
  // Fetch port
  //////////////////////////////////////////////////
  assign fetch_widx = fetch_addr[WADDR_W:1];  // Wraps modulo the depth
  assign fetch_data = mem_q[fetch_widx];

  //////////////////////////////////////////////////
  // APB decode
  //////////////////////////////////////////////////
  assign apb_access = psel & penable;
  assign apb_widx   = paddr[WADDR_W:1];
  assign addr_err   = paddr[0] | ({1'b0, paddr} >= BYTE_LIMIT);

  assign pready  = apb_access;             // Zero wait states
  assign pslverr = apb_access & addr_err;  // Flag only in the access cycle
  assign apb_wr  = apb_access & pwrite & ~addr_err;

  // Read data only for a good read access, zero otherwise
  always_comb begin
    prdata = '0;
    if (apb_access && !pwrite && !addr_err) begin
      prdata = mem_q[apb_widx];
    end
  end

  // Store at the end of the access cycle
  always_ff @(posedge clk) begin
    if (apb_wr) begin
      mem_q[apb_widx] <= pwdata;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  // Host must open every transfer with a setup phase
  a_penable_psel : assert property (@(posedge clk) disable iff (!rst_n)
    penable |-> psel)
    else $error("APB penable without psel");

endmodule

`default_nettype wire

// ==== verilog/pred_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module pred_table #(
  parameter type ENTRY_T  = logic,
  parameter int  DEPTH    = `PRED_ENTRIES,
  parameter ENTRY_T INIT_VAL = '0
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire fetch_pkg::pred_idx_t rd_idx,   // Lookup index
  output ENTRY_T               rd_data,       // Entry at rd_idx, no clock
  input  wire                  wr_en,
  input  wire fetch_pkg::pred_idx_t wr_idx,
  input  wire ENTRY_T          wr_data,
  output ENTRY_T               wr_old         // Entry at wr_idx before the write
);

  ENTRY_T table_q [DEPTH];  // Direct mapped storage, no tags

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        table_q[i] <= INIT_VAL;  // Every entry back to its idle value
      end
    end else if (wr_en) begin
      table_q[wr_idx] <= wr_data;
    end
  end

  // Both reads are asynchronous
  assign rd_data = table_q[rd_idx];
  assign wr_old  = table_q[wr_idx];  // Lets the owner do read-modify-write

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  // An X index on a write would smear an unknown entry into the table
  a_wr_idx_known : assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> !$isunknown(wr_idx))
    else $error("pred_table write with unknown index");

endmodule

`default_nettype wire
